//--- verilog.f
qspi_pkg.sv
axil_port_arbiter.sv
qspi_reg_stage.sv
qspi_shift_engine.sv
qspi_subsystem.sv
tb_flash_model.sv
tb_qspi_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the QSPI bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_qspi_subsystem --Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- tb_qspi_subsystem.sv
`timescale 1ns/1ps

module tb_qspi_subsystem;

    logic                      aclk;
    logic                      arst_n;
    qspi_pkg::axil_m2s_t [1:0] m2s;   // Port 0 is PS, port 1 is PCIe
    qspi_pkg::axil_s2m_t [1:0] s2m;
    logic                      sck;
    logic                      csn;
    logic [3:0]                miso;
    logic [3:0]                mosi;
    logic                      flash_quad;
    integer                    seed;
    int                        byte_count;
    int                        sck_rises;
    logic [7:0]                expected_rx;   // Flash answer for the next byte
    logic [7:0]                tx_seq [3];

    qspi_subsystem dut0 (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .ps_m2s   (m2s[0]),
        .ps_s2m   (s2m[0]),
        .pcie_m2s (m2s[1]),
        .pcie_s2m (s2m[1]),
        .sck      (sck),
        .csn      (csn),
        .miso     (miso),
        .mosi     (mosi)
    );

    tb_flash_model flash0 (.sck(sck), .csn(csn), .quad(flash_quad), .mosi(mosi), .miso(miso));

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    always @(posedge sck) sck_rises = sck_rises + 1;

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            report_error($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
    endtask

    // Hold keeps bready low that many cycles after bvalid
    task automatic axil_write(input int port, input logic [11:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input int hold = 0);
        logic [1:0] resp;
        @(posedge aclk);
        m2s[port].awaddr  <= addr;
        m2s[port].wdata   <= data;
        m2s[port].wstrb   <= 4'hF;
        m2s[port].awvalid <= 1'b1;
        m2s[port].wvalid  <= 1'b1;
        m2s[port].bready  <= (hold == 0);
        do @(posedge aclk); while (!s2m[port].awready);
        m2s[port].awvalid <= 1'b0;
        m2s[port].wvalid  <= 1'b0;
        while (!s2m[port].bvalid) @(posedge aclk);
        resp = s2m[port].bresp;
        if (hold > 0) begin
            repeat (hold) begin
                @(posedge aclk);
                assert (s2m[port].bvalid && s2m[port].bresp === resp) else
                    report_error("held B response dropped or changed before bready");
            end
            m2s[port].bready <= 1'b1;
            @(posedge aclk);
        end
        m2s[port].bready <= 1'b0;
        check_value("bresp", 32'(resp), 32'(exp_resp));
    endtask

    task automatic read_word(input int port, input logic [11:0] addr,
                             output logic [31:0] data, output logic [1:0] resp);
        @(posedge aclk);
        m2s[port].araddr  <= addr;
        m2s[port].arvalid <= 1'b1;
        m2s[port].rready  <= 1'b1;
        do @(posedge aclk); while (!s2m[port].arready);
        m2s[port].arvalid <= 1'b0;
        while (!s2m[port].rvalid) @(posedge aclk);
        data = s2m[port].rdata;
        resp = s2m[port].rresp;
        m2s[port].rready <= 1'b0;
    endtask

    task automatic axil_read(input int port, input logic [11:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        read_word(port, addr, data, resp);
        check_value("rresp", 32'(resp), 32'(exp_resp));
        check_value("rdata", data, exp_data);
    endtask

    // One byte on the wire with an optional rejected write while busy
    task automatic send_byte(input logic [7:0] tx, input logic try_busy);
        logic [31:0] status;
        logic [1:0]  resp;
        int          rises_before;
        rises_before = sck_rises;
        axil_write(0, qspi_pkg::REG_TXDATA, {24'h0, tx}, 2'b00);
        if (try_busy) axil_write(1, qspi_pkg::REG_TXDATA, 32'h5A, 2'b10);
        do read_word(0, qspi_pkg::REG_STATUS, status, resp); while (status[0]);
        byte_count = byte_count + 1;
        check_value("byte counter", 32'(status[15:8]), 32'(byte_count % 256));
        check_value("sck rising edges", 32'(sck_rises - rises_before), flash_quad ? 2 : 8);
        axil_read(1, qspi_pkg::REG_RXDATA, {24'h0, expected_rx}, 2'b00);
        axil_read(0, qspi_pkg::REG_TXDATA, {24'h0, tx}, 2'b00);
        expected_rx = tx ^ 8'hA5;
    endtask

    task automatic reset_state();
        repeat (2) @(posedge aclk);
        assert (csn === 1'b1 && sck === 1'b0 && mosi === 4'h0) else
            report_error("SPI pins not idle in reset");
        assert (!s2m[0].bvalid && !s2m[0].rvalid && !s2m[1].bvalid && !s2m[1].rvalid) else
            report_error("bus response valid during reset");
        arst_n <= 1'b1;
        @(posedge aclk);
        assert (csn === 1'b1 && sck === 1'b0 && mosi === 4'h0) else
            report_error("SPI pins not idle after reset");
        axil_read(0, qspi_pkg::REG_STATUS, 32'h0, 2'b00);
    endtask

    task automatic shared_registers();
        logic [31:0] val;
        val = $random(seed);
        axil_write(0, qspi_pkg::REG_CTRL, val, 2'b00);
        axil_read(1, qspi_pkg::REG_CTRL, val & 32'h1F1, 2'b00);   // quad, clkdiv, cs_hold
        val = $random(seed);
        axil_write(1, qspi_pkg::REG_CTRL, val, 2'b00);
        axil_read(0, qspi_pkg::REG_CTRL, val & 32'h1F1, 2'b00);
        axil_write(1, qspi_pkg::REG_STATUS, 32'hFFFF_FFFF, 2'b10);
        axil_read(0, 12'h010, 32'h0, 2'b10);
        axil_read(1, qspi_pkg::REG_STATUS, 32'h0, 2'b00);
    endtask

    task automatic single_mode_bytes();
        for (int i = 0; i < 3; i++) tx_seq[i] = 8'($random(seed));
        axil_write(0, qspi_pkg::REG_CTRL, 32'h120, 2'b00);   // cs_hold, clkdiv 2
        expected_rx = 8'hFF;
        for (int i = 0; i < 3; i++) send_byte(tx_seq[i], 1'b0);
        axil_write(1, qspi_pkg::REG_CTRL, 32'h020, 2'b00);
        @(posedge aclk);
        assert (csn === 1'b1) else report_error("CSn still low after cs_hold was cleared");
    endtask

    task automatic quad_mode_bytes();
        flash_quad <= 1'b1;
        axil_write(0, qspi_pkg::REG_CTRL, 32'h101, 2'b00);   // cs_hold, clkdiv 0, quad
        expected_rx = 8'hFF;
        for (int i = 0; i < 3; i++) send_byte(tx_seq[i], 1'b0);
        axil_write(1, qspi_pkg::REG_CTRL, 32'h1F1, 2'b00);   // Slow SCK leaves time to collide
        send_byte(8'($random(seed)), 1'b1);
    endtask

    task automatic dual_port_contention();
        fork
            axil_write(1, qspi_pkg::REG_CTRL, 32'h030, 2'b00, 6);   // Wins the tie, holds B
            axil_read(0, qspi_pkg::REG_STATUS, 32'(byte_count % 256) << 8, 2'b00);
        join
        axil_read(1, qspi_pkg::REG_CTRL, 32'h030, 2'b00);
        assert (csn === 1'b1) else report_error("CSn not released by the CTRL write");
    endtask

    // 200 us covers every test at clkdiv 15 with wide margin
    initial begin
        repeat (50_000) @(posedge aclk);
        $display("Timeout: the tests did not finish in time");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed        = 87;
        arst_n      = 1'b0;
        m2s         = '0;
        flash_quad  = 1'b0;
        byte_count  = 0;
        sck_rises   = 0;
        expected_rx = 8'hFF;
        reset_state();
        shared_registers();
        single_mode_bytes();
        quad_mode_bytes();
        dual_port_contention();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model (
    input  logic       sck,
    input  logic       csn,
    input  logic       quad,
    input  logic [3:0] mosi,
    output logic [3:0] miso
);

    logic [7:0] in_sr;    // Byte arriving on mosi
    logic [7:0] out_sr;   // Byte going out on miso
    logic [3:0] beats;    // Rising SCK edges in the current byte

    // Top beat of a byte on the lines, IO1 only in single mode
    function automatic logic [3:0] top_beat(input logic q, input logic [7:0] b);
        logic [3:0] lines;
        lines = q ? b[7:4] : {2'b00, b[7], 1'b0};
        return lines;
    endfunction

    initial begin
        in_sr  = 8'h00;
        out_sr = 8'hFF;
        beats  = 4'd0;
        miso   = 4'h0;
    end

    // First byte of a session answers 0xFF
    always @(negedge csn) begin
        out_sr = 8'hFF;
        beats  = 4'd0;
        miso   = top_beat(quad, 8'hFF);
    end

    always @(posedge csn) miso = 4'h0;

    always @(posedge sck) begin
        if (csn === 1'b0) begin
            in_sr = quad ? {in_sr[3:0], mosi} : {in_sr[6:0], mosi[0]};
            beats = beats + 4'd1;
        end
    end

    always @(negedge sck) begin
        if (csn === 1'b0) begin
            if (beats == (quad ? 4'd2 : 4'd8)) begin
                out_sr = in_sr ^ 8'hA5;   // Answer for the byte just received
                beats  = 4'd0;
            end else begin
                out_sr = quad ? {out_sr[3:0], 4'h0} : {out_sr[6:0], 1'b0};
            end
            miso = top_beat(quad, out_sr);
        end
    end

endmodule

//--- qspi_subsystem.sv
`timescale 1ns/1ps

module qspi_subsystem (
    input  logic                aclk,
    input  logic                arst_n,
    input  qspi_pkg::axil_m2s_t ps_m2s,
    output qspi_pkg::axil_s2m_t ps_s2m,
    input  qspi_pkg::axil_m2s_t pcie_m2s,
    output qspi_pkg::axil_s2m_t pcie_s2m,
    output logic                sck,
    output logic                csn,
    input  logic [3:0]          miso,
    output logic [3:0]          mosi
);

    qspi_pkg::reg_req_t req;
    qspi_pkg::reg_rsp_t rsp;
    qspi_pkg::spi_cmd_t cmd;
    qspi_pkg::spi_rsp_t spi;

    // One access at a time from either bus
    axil_port_arbiter arb_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .ps_m2s   (ps_m2s),
        .ps_s2m   (ps_s2m),
        .pcie_m2s (pcie_m2s),
        .pcie_s2m (pcie_s2m),
        .req      (req),
        .rsp      (rsp)
    );

    qspi_reg_stage regs_i (
        .aclk   (aclk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp),
        .cmd    (cmd),
        .spi    (spi)
    );

    qspi_shift_engine shift_i (
        .aclk   (aclk),
        .arst_n (arst_n),
        .cmd    (cmd),
        .rsp    (spi),
        .sck    (sck),
        .csn    (csn),
        .miso   (miso),
        .mosi   (mosi)
    );

endmodule

//--- qspi_shift_engine.sv
`timescale 1ns/1ps

module qspi_shift_engine (
    input  logic               aclk,
    input  logic               arst_n,
    input  qspi_pkg::spi_cmd_t cmd,
    output qspi_pkg::spi_rsp_t rsp,
    output logic               sck,
    output logic               csn,
    input  logic [3:0]         miso,
    output logic [3:0]         mosi
);

    qspi_pkg::shift_state_e          state;
    logic [qspi_pkg::CLKDIV_W-1:0]   div_cnt;
    logic [qspi_pkg::CLKDIV_W-1:0]   clkdiv_q;
    logic [2:0]                      bit_cnt;    // Beats left after the current one
    logic                            quad_q;
    logic                            cs_hold_q;
    logic [7:0]                      tx_sr;
    logic [7:0]                      rx_sr;
    logic [7:0]                      tx_next;
    logic                            half_done;

    // Lines driven for the top of a shift register
    function automatic logic [3:0] lanes(input logic quad, input logic [7:0] sr);
        logic [3:0] out;
        out = quad ? sr[7:4] : {3'b000, sr[7]};
        return out;
    endfunction

    assign half_done = div_cnt == clkdiv_q;
    assign tx_next   = quad_q ? {tx_sr[3:0], 4'b0} : {tx_sr[6:0], 1'b0};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= qspi_pkg::SH_IDLE;
            div_cnt   <= '0;
            clkdiv_q  <= '0;
            bit_cnt   <= '0;
            quad_q    <= 1'b0;
            cs_hold_q <= 1'b0;
            sck       <= 1'b0;
            csn       <= 1'b1;
            mosi      <= '0;
        end else begin
            case (state)
                qspi_pkg::SH_IDLE: begin
                    if (cmd.valid) begin
                        quad_q    <= cmd.quad;
                        clkdiv_q  <= cmd.clkdiv;
                        cs_hold_q <= cmd.cs_hold;
                        bit_cnt   <= cmd.quad ? 3'd1 : 3'd7;
                        div_cnt   <= '0;
                        csn       <= 1'b0;
                        mosi      <= lanes(cmd.quad, cmd.data);   // Half period ahead of SCK
                        state     <= qspi_pkg::SH_SETUP;
                    end else if (cmd.cs_release) begin
                        csn <= 1'b1;
                    end
                end
                qspi_pkg::SH_SETUP, qspi_pkg::SH_LOW: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sck     <= 1'b1;   // Rising edge, flash samples
                        state   <= qspi_pkg::SH_HIGH;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                qspi_pkg::SH_HIGH: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sck     <= 1'b0;
                        if (bit_cnt == 3'd0) begin
                            state <= qspi_pkg::SH_DONE;
                        end else begin
                            bit_cnt <= bit_cnt - 3'd1;
                            mosi    <= lanes(quad_q, tx_next);
                            state   <= qspi_pkg::SH_LOW;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                qspi_pkg::SH_DONE: begin
                    csn   <= !cs_hold_q;
                    state <= qspi_pkg::SH_IDLE;
                end
                default: state <= qspi_pkg::SH_IDLE;
            endcase
        end
    end

    // Data shifters
    always_ff @(posedge aclk) begin
        if (state == qspi_pkg::SH_IDLE && cmd.valid) begin
            tx_sr <= cmd.data;
        end else if (state == qspi_pkg::SH_HIGH && half_done) begin
            tx_sr <= tx_next;   // Falling edge
        end
        if ((state == qspi_pkg::SH_SETUP || state == qspi_pkg::SH_LOW) && half_done) begin
            if (quad_q) begin
                rx_sr <= {rx_sr[3:0], miso};
            end else begin
                rx_sr <= {rx_sr[6:0], miso[1]};   // Standard flash returns on IO1
            end
        end
    end

    assign rsp.busy    = state != qspi_pkg::SH_IDLE;
    assign rsp.done    = state == qspi_pkg::SH_DONE;
    assign rsp.rx_data = rx_sr;

endmodule

//--- qspi_reg_stage.sv
`timescale 1ns/1ps

module qspi_reg_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  qspi_pkg::reg_req_t req,
    output qspi_pkg::reg_rsp_t rsp,
    output qspi_pkg::spi_cmd_t cmd,
    input  qspi_pkg::spi_rsp_t spi
);

    logic                                ctrl_quad;
    logic [qspi_pkg::CLKDIV_W-1:0]       ctrl_clkdiv;
    logic                                ctrl_cs_hold;
    logic [7:0]                          tx_data;
    logic [7:0]                          rx_data;
    logic [7:0]                          byte_cnt;   // Wraps at 256
    logic                                busy;
    logic [qspi_pkg::AXI_DATA_W-1:0]     ctrl_word;
    logic [qspi_pkg::AXI_DATA_W-1:0]     status_word;
    logic [qspi_pkg::AXI_DATA_W-1:0]     rd_data;
    logic                                acc_err;
    logic [7:0]                          ctrl_lo;
    logic [7:0]                          ctrl_hi;
    qspi_pkg::spi_cmd_t                  cmd_q;
    qspi_pkg::reg_rsp_t                  rsp_q;

    // Command in flight counts as busy before the engine answers
    assign busy = spi.busy || cmd_q.valid;

    assign ctrl_word   = {23'b0, ctrl_cs_hold, ctrl_clkdiv, 3'b0, ctrl_quad};
    assign status_word = {16'b0, byte_cnt, 7'b0, busy};

    // CTRL bytes after byte strobes
    assign ctrl_lo = req.wstrb[0] ? req.wdata[7:0]  : ctrl_word[7:0];
    assign ctrl_hi = req.wstrb[1] ? req.wdata[15:8] : ctrl_word[15:8];

    always_comb begin
        rd_data = '0;
        acc_err = 1'b0;
        case (qspi_pkg::reg_addr_e'(req.addr))
            qspi_pkg::REG_CTRL: rd_data = ctrl_word;
            qspi_pkg::REG_TXDATA: begin
                rd_data = {24'b0, tx_data};
                acc_err = req.write && busy;   // No new byte while shifting
            end
            qspi_pkg::REG_RXDATA: begin
                rd_data = {24'b0, rx_data};
                acc_err = req.write;
            end
            qspi_pkg::REG_STATUS: begin
                rd_data = status_word;
                acc_err = req.write;
            end
            default: acc_err = 1'b1;   // Unmapped, reads give 0
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_quad    <= 1'b0;
            ctrl_clkdiv  <= '0;
            ctrl_cs_hold <= 1'b0;
            tx_data      <= '0;
            rx_data      <= '0;
            byte_cnt     <= '0;
            cmd_q        <= '0;
            rsp_q        <= '0;
        end else begin
            cmd_q.valid      <= 1'b0;
            cmd_q.cs_release <= 1'b0;
            rsp_q.valid      <= req.valid;
            if (req.valid) begin
                rsp_q.rdata <= (req.write || acc_err) ? '0 : rd_data;
                rsp_q.err   <= acc_err;
            end

            if (req.valid && req.write && !acc_err) begin
                case (qspi_pkg::reg_addr_e'(req.addr))
                    qspi_pkg::REG_CTRL: begin
                        ctrl_quad    <= ctrl_lo[0];
                        ctrl_clkdiv  <= ctrl_lo[7:4];
                        ctrl_cs_hold <= ctrl_hi[0];
                        if (!ctrl_hi[0] && !busy) begin
                            cmd_q.cs_release <= 1'b1;   // Let CSn go high
                        end
                    end
                    qspi_pkg::REG_TXDATA: begin
                        tx_data       <= req.wdata[7:0];
                        cmd_q.valid   <= 1'b1;
                        cmd_q.quad    <= ctrl_quad;
                        cmd_q.clkdiv  <= ctrl_clkdiv;
                        cmd_q.cs_hold <= ctrl_cs_hold;
                        cmd_q.data    <= req.wdata[7:0];
                    end
                    default: ;
                endcase
            end

            if (spi.done) begin
                rx_data  <= spi.rx_data;
                byte_cnt <= byte_cnt + 8'd1;
            end
        end
    end

    assign cmd = cmd_q;
    assign rsp = rsp_q;

endmodule

//--- axil_port_arbiter.sv
`timescale 1ns/1ps

module axil_port_arbiter (
    input  logic                aclk,
    input  logic                arst_n,
    input  qspi_pkg::axil_m2s_t ps_m2s,
    output qspi_pkg::axil_s2m_t ps_s2m,
    input  qspi_pkg::axil_m2s_t pcie_m2s,
    output qspi_pkg::axil_s2m_t pcie_s2m,
    output qspi_pkg::reg_req_t  req,
    input  qspi_pkg::reg_rsp_t  rsp
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_ISSUE, ARB_WAIT, ARB_HOLD} arb_state_e;

    arb_state_e                            state;
    qspi_pkg::axil_m2s_t                   m2s [qspi_pkg::NUM_PORTS];
    qspi_pkg::axil_s2m_t                   s2m [qspi_pkg::NUM_PORTS];
    logic [qspi_pkg::NUM_PORTS-1:0]        want;
    logic                                  pick;
    logic                                  sel;        // Granted port
    logic                                  last;       // Port served last
    logic                                  sel_write;
    logic                                  req_valid;
    logic [qspi_pkg::AXI_ADDR_W-1:0]       req_addr;
    logic [qspi_pkg::AXI_DATA_W-1:0]       req_wdata;
    logic [qspi_pkg::AXI_DATA_W/8-1:0]     req_wstrb;
    logic [qspi_pkg::AXI_DATA_W-1:0]       rsp_data;
    logic                                  rsp_err;

    assign m2s[0]   = ps_m2s;
    assign m2s[1]   = pcie_m2s;
    assign ps_s2m   = s2m[0];
    assign pcie_s2m = s2m[1];

    always_comb begin
        for (int p = 0; p < qspi_pkg::NUM_PORTS; p++) begin
            want[p] = (m2s[p].awvalid && m2s[p].wvalid) || m2s[p].arvalid;
        end
        pick = (want[0] && want[1]) ? ~last : want[1];   // Round robin on a tie
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            sel       <= 1'b0;
            last      <= 1'b0;
            sel_write <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                ARB_IDLE: if (|want) begin
                    sel       <= pick;
                    sel_write <= m2s[pick].awvalid && m2s[pick].wvalid;   // Write first
                    state     <= ARB_ISSUE;
                end
                ARB_ISSUE: begin
                    req_valid <= 1'b1;
                    state     <= ARB_WAIT;
                end
                ARB_WAIT: if (rsp.valid) state <= ARB_HOLD;
                ARB_HOLD: if (sel_write ? m2s[sel].bready : m2s[sel].rready) begin
                    last  <= sel;
                    state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Request payload and held response
    always_ff @(posedge aclk) begin
        if (state == ARB_ISSUE) begin
            req_addr  <= sel_write ? m2s[sel].awaddr : m2s[sel].araddr;
            req_wdata <= m2s[sel].wdata;
            req_wstrb <= sel_write ? m2s[sel].wstrb : '0;
        end
        if (state == ARB_WAIT && rsp.valid) begin
            rsp_data <= rsp.rdata;
            rsp_err  <= rsp.err;
        end
    end

    assign req = '{valid: req_valid, write: sel_write, addr: req_addr,
                   wdata: req_wdata, wstrb: req_wstrb};

    always_comb begin
        for (int p = 0; p < qspi_pkg::NUM_PORTS; p++) begin
            s2m[p]         = '0;
            s2m[p].awready = state == ARB_ISSUE && sel == 1'(p) && sel_write;
            s2m[p].wready  = state == ARB_ISSUE && sel == 1'(p) && sel_write;
            s2m[p].arready = state == ARB_ISSUE && sel == 1'(p) && !sel_write;
            s2m[p].bvalid  = state == ARB_HOLD && sel == 1'(p) && sel_write;
            s2m[p].rvalid  = state == ARB_HOLD && sel == 1'(p) && !sel_write;
            s2m[p].bresp   = rsp_err ? 2'b10 : 2'b00;
            s2m[p].rresp   = rsp_err ? 2'b10 : 2'b00;
            s2m[p].rdata   = rsp_data;
        end
    end

endmodule

//--- qspi_pkg.sv
package qspi_pkg;

    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;
    localparam int NUM_PORTS  = 2;   // 0 is PS, 1 is PCIe
    localparam int CLKDIV_W   = 4;

    // Word offsets of the register file
    typedef enum logic [AXI_ADDR_W-1:0] {
        REG_CTRL   = 12'h000,
        REG_TXDATA = 12'h004,
        REG_RXDATA = 12'h008,
        REG_STATUS = 12'h00C
    } reg_addr_e;

    typedef enum logic [2:0] {
        SH_IDLE,
        SH_SETUP,   // CSn low, first bit on the wire
        SH_LOW,
        SH_HIGH,
        SH_DONE
    } shift_state_e;

    // AXI4-Lite master to slave
    typedef struct packed {
        logic [AXI_ADDR_W-1:0]   awaddr;
        logic                    awvalid;
        logic [AXI_DATA_W-1:0]   wdata;
        logic [AXI_DATA_W/8-1:0] wstrb;
        logic                    wvalid;
        logic                    bready;
        logic [AXI_ADDR_W-1:0]   araddr;
        logic                    arvalid;
        logic                    rready;
    } axil_m2s_t;

    // AXI4-Lite slave to master
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic [1:0]            bresp;
        logic                  bvalid;
        logic                  arready;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rvalid;
    } axil_s2m_t;

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [AXI_ADDR_W-1:0]   addr;
        logic [AXI_DATA_W-1:0]   wdata;
        logic [AXI_DATA_W/8-1:0] wstrb;
    } reg_req_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_DATA_W-1:0] rdata;
        logic                  err;
    } reg_rsp_t;

    typedef struct packed {
        logic                valid;
        logic                quad;
        logic [CLKDIV_W-1:0] clkdiv;
        logic                cs_hold;
        logic                cs_release;   // Raise CSn, no byte
        logic [7:0]          data;
    } spi_cmd_t;

    typedef struct packed {
        logic       busy;
        logic       done;
        logic [7:0] rx_data;
    } spi_rsp_t;

endpackage
